/* hw/udp_demux_pkg.sv */
/*
 * Shared types for the UDP frame demultiplexer: header fields, payload beat
 * and the per-frame state. Modules pull these in with a wildcard import.
 */
`default_nettype none

package udp_demux_pkg;

    // header field widths
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [15:0] udp_csum_t;

    // 128 bits, source ip in the top word
    typedef struct packed {
        ip_addr_t  ip_source_ip;
        ip_addr_t  ip_dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
        udp_csum_t checksum;
    } udp_hdr_t;

    localparam int PAYLOAD_WIDTH = 32;
    localparam int KEEP_WIDTH = PAYLOAD_WIDTH / 8;

    typedef logic [PAYLOAD_WIDTH-1:0] payload_data_t;
    typedef logic [KEEP_WIDTH-1:0]    payload_keep_t;

    typedef struct packed {
        payload_data_t data;
        payload_keep_t keep;
        logic          last;
    } payload_beat_t;

    // where the payload of the current frame goes
    typedef enum logic [1:0] {
        FRAME_IDLE    = 2'd0,
        FRAME_FORWARD = 2'd1,
        FRAME_DISCARD = 2'd2
    } frame_state_t;

endpackage

`default_nettype wire

/* hw/udp_frame_ctrl.sv */
/*
 * Frame controller for the UDP demux. Takes one header per frame, latches
 * select and drop, presents the header to the chosen port and paces the input.
 */
`timescale 1ns/1ps
`default_nettype none

module udp_frame_ctrl
    import udp_demux_pkg::*;
#(
    parameter int M_COUNT = 4,
    localparam int SEL_WIDTH = (M_COUNT > 1) ? $clog2(M_COUNT) : 1
) (
    input  wire                  clk,
    input  wire                  rst,

    input  wire                  enable,
    input  wire                  drop,
    input  wire [SEL_WIDTH-1:0]  select,

    // header in and out
    input  wire                  s_hdr_valid,
    output logic                 s_hdr_ready,
    input  wire udp_hdr_t        s_hdr,
    output logic [M_COUNT-1:0]   m_hdr_valid,
    input  wire [M_COUNT-1:0]    m_hdr_ready,
    output udp_hdr_t             m_hdr,

    // payload handshake, the beat itself bypasses this block
    input  wire                  s_payload_valid,
    output logic                 s_payload_ready,
    input  wire                  s_payload_last,
    input  wire                  skid_ready_early,
    output logic [M_COUNT-1:0]   route_valid
);

    frame_state_t state_reg;
    frame_state_t state_next;

    logic [SEL_WIDTH-1:0] select_reg;
    logic [SEL_WIDTH-1:0] select_next;

    logic [M_COUNT-1:0] m_hdr_valid_reg;
    logic [M_COUNT-1:0] m_hdr_valid_next;
    udp_hdr_t           hdr_reg;

    logic s_hdr_ready_reg;
    logic s_hdr_ready_next;
    logic s_payload_ready_reg;
    logic s_payload_ready_next;

    logic hdr_xfer;
    logic payload_xfer;

    // input side stalls whenever enable is low
    assign s_hdr_ready = s_hdr_ready_reg && enable;
    assign s_payload_ready = s_payload_ready_reg && enable;

    assign hdr_xfer = s_hdr_valid && s_hdr_ready;
    assign payload_xfer = s_payload_valid && s_payload_ready;

    assign m_hdr_valid = m_hdr_valid_reg;
    assign m_hdr = hdr_reg;

    // one-hot strobe into the skid buffer, forwarded frames only
    assign route_valid = (payload_xfer && state_reg == FRAME_FORWARD)
                       ? (M_COUNT'(1) << select_reg) : '0;

    always_comb begin
        state_next = state_reg;
        select_next = select_reg;
        m_hdr_valid_next = m_hdr_valid_reg & ~m_hdr_ready;

        if (hdr_xfer) begin
            // start of frame
            select_next = select;
            if (drop) begin
                state_next = FRAME_DISCARD;
                m_hdr_valid_next = '0;
            end else begin
                state_next = FRAME_FORWARD;
                m_hdr_valid_next = M_COUNT'(1) << select;
            end
        end else if (payload_xfer && s_payload_last) begin
            state_next = FRAME_IDLE;
        end

        // next header waits for frame end and for the old header to leave
        s_hdr_ready_next = (state_next == FRAME_IDLE) && (m_hdr_valid_next == '0);

        case (state_next)
            FRAME_FORWARD: s_payload_ready_next = skid_ready_early;
            FRAME_DISCARD: s_payload_ready_next = 1'b1;
            default:       s_payload_ready_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= FRAME_IDLE;
            select_reg <= '0;
            m_hdr_valid_reg <= '0;
            s_hdr_ready_reg <= 1'b0;
            s_payload_ready_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            select_reg <= select_next;
            m_hdr_valid_reg <= m_hdr_valid_next;
            s_hdr_ready_reg <= s_hdr_ready_next;
            s_payload_ready_reg <= s_payload_ready_next;
        end
    end

    // header fields held for the output port
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            hdr_reg <= s_hdr;
        end
    end

endmodule

`default_nettype wire

/* hw/udp_payload_skid.sv */
/*
 * Two-register skid buffer for payload beats. The one-hot valid vector
 * picks the output port; skid_ready_early feeds the registered input ready.
 */
`timescale 1ns/1ps
`default_nettype none

module udp_payload_skid
    import udp_demux_pkg::*;
#(
    parameter int M_COUNT = 4
) (
    input  wire                 clk,
    input  wire                 rst,

    input  wire [M_COUNT-1:0]   in_valid,
    input  wire payload_beat_t  in_beat,
    output logic                skid_ready_early,

    output logic [M_COUNT-1:0]  out_valid,
    input  wire [M_COUNT-1:0]   out_ready,
    output payload_beat_t       out_beat
);

    logic [M_COUNT-1:0] out_valid_reg;
    logic [M_COUNT-1:0] out_valid_next;
    logic [M_COUNT-1:0] temp_valid_reg;
    logic [M_COUNT-1:0] temp_valid_next;

    payload_beat_t out_beat_reg;
    payload_beat_t temp_beat_reg;

    logic in_any;
    logic out_taken;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign in_any = |in_valid;
    assign out_taken = |(out_ready & out_valid_reg);

    assign out_valid = out_valid_reg;
    assign out_beat = out_beat_reg;

    // room next cycle unless temp is busy or about to be
    assign skid_ready_early = out_taken
                           || (temp_valid_reg == '0 && (out_valid_reg == '0 || !in_any));

    always_comb begin
        out_valid_next = out_valid_reg;
        temp_valid_next = temp_valid_reg;
        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_any) begin
            if (out_taken || out_valid_reg == '0) begin
                // straight to the output
                out_valid_next = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park it
                temp_valid_next = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_taken) begin
            // drain the parked beat, or go empty
            out_valid_next = temp_valid_reg;
            temp_valid_next = '0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= '0;
            temp_valid_reg <= '0;
        end else begin
            out_valid_reg <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat_reg <= in_beat;
        end else if (store_temp_to_out) begin
            out_beat_reg <= temp_beat_reg;
        end

        if (store_in_to_temp) begin
            temp_beat_reg <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* hw/udp_demux_top.sv */
/*
 * UDP frame demultiplexer top level. Routes each header and its payload to
 * one of M_COUNT ports, or swallows the frame when drop is set at its header.
 */
`timescale 1ns/1ps
`default_nettype none

module udp_demux_top
    import udp_demux_pkg::*;
#(
    parameter int M_COUNT = 4,
    localparam int SEL_WIDTH = (M_COUNT > 1) ? $clog2(M_COUNT) : 1
) (
    input  wire                  clk,
    input  wire                  rst,

    // frame input
    input  wire                  s_hdr_valid,
    output logic                 s_hdr_ready,
    input  wire udp_hdr_t        s_hdr,
    input  wire                  s_payload_valid,
    output logic                 s_payload_ready,
    input  wire payload_beat_t   s_payload,

    // shared buses, per-port handshakes
    output logic [M_COUNT-1:0]   m_hdr_valid,
    input  wire [M_COUNT-1:0]    m_hdr_ready,
    output udp_hdr_t             m_hdr,
    output logic [M_COUNT-1:0]   m_payload_valid,
    input  wire [M_COUNT-1:0]    m_payload_ready,
    output payload_beat_t        m_payload,

    input  wire                  enable,
    input  wire                  drop,
    input  wire [SEL_WIDTH-1:0]  select
);

    logic [M_COUNT-1:0] route_valid;
    logic               skid_ready_early;

    udp_frame_ctrl #(
        .M_COUNT(M_COUNT)
    ) frame_ctrl0 (
        .clk              (clk),
        .rst              (rst),
        .enable           (enable),
        .drop             (drop),
        .select           (select),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr_ready      (s_hdr_ready),
        .s_hdr            (s_hdr),
        .m_hdr_valid      (m_hdr_valid),
        .m_hdr_ready      (m_hdr_ready),
        .m_hdr            (m_hdr),
        .s_payload_valid  (s_payload_valid),
        .s_payload_ready  (s_payload_ready),
        .s_payload_last   (s_payload.last),
        .skid_ready_early (skid_ready_early),
        .route_valid      (route_valid)
    );

    // payload beat goes straight in, qualified by route_valid
    udp_payload_skid #(
        .M_COUNT(M_COUNT)
    ) payload_skid0 (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (route_valid),
        .in_beat          (s_payload),
        .skid_ready_early (skid_ready_early),
        .out_valid        (m_payload_valid),
        .out_ready        (m_payload_ready),
        .out_beat         (m_payload)
    );

endmodule

`default_nettype wire

/* verification/udp_demux_vectors.svh */
/*
 * Frame table for the UDP demux testbench, included inside the testbench module.
 * Columns: select, drop, source ip, dest ip, source port, dest port, checksum,
 * payload beats, back-pressure, enable mode (0 on, 1 off at header, 2 off mid-payload).
 */
`ifndef UDP_DEMUX_VECTORS_SVH
`define UDP_DEMUX_VECTORS_SVH

localparam int NUM_FRAMES = 12;

typedef struct packed {
    logic [1:0] sel;
    logic       drop;
    ip_addr_t   src_ip;
    ip_addr_t   dst_ip;
    udp_port_t  src_port;
    udp_port_t  dst_port;
    udp_csum_t  csum;
    logic [7:0] beats;
    logic       bp;
    logic [1:0] en_mode;
} frame_vec_t;

frame_vec_t frame_table [NUM_FRAMES];

task automatic load_frame_table();
    frame_table[0]  = '{2'd0, 1'b0, 32'hc0a80001, 32'hc0a80002, 16'd1000, 16'd2000,
                        16'h1a2b, 8'd4, 1'b0, 2'd0};
    frame_table[1]  = '{2'd1, 1'b0, 32'h0a000001, 32'h0a000002, 16'd53, 16'd1053,
                        16'h0000, 8'd1, 1'b0, 2'd0};
    // dropped, then a normal frame right behind it
    frame_table[2]  = '{2'd2, 1'b1, 32'hac100001, 32'hac100002, 16'd4000, 16'd4001,
                        16'hbeef, 8'd6, 1'b0, 2'd0};
    frame_table[3]  = '{2'd3, 1'b0, 32'hac100003, 32'hac100004, 16'd4002, 16'd4003,
                        16'h1234, 8'd5, 1'b0, 2'd0};
    frame_table[4]  = '{2'd2, 1'b0, 32'h7f000001, 32'h7f000002, 16'd8080, 16'd80,
                        16'hffff, 8'd16, 1'b1, 2'd0};
    frame_table[5]  = '{2'd0, 1'b1, 32'h01020304, 32'h05060708, 16'd1, 16'd2,
                        16'h5a5a, 8'd3, 1'b1, 2'd0};
    frame_table[6]  = '{2'd1, 1'b0, 32'hdeadbeef, 32'hcafef00d, 16'd5353, 16'd5354,
                        16'h00ff, 8'd8, 1'b1, 2'd0};
    frame_table[7]  = '{2'd3, 1'b0, 32'hc0a80a0a, 32'hc0a80a0b, 16'd67, 16'd68,
                        16'h0f0f, 8'd6, 1'b0, 2'd1};
    frame_table[8]  = '{2'd0, 1'b0, 32'h08080808, 32'h08080404, 16'd123, 16'd124,
                        16'h4321, 8'd10, 1'b1, 2'd2};
    frame_table[9]  = '{2'd2, 1'b1, 32'h11111111, 32'h22222222, 16'd9, 16'd10,
                        16'h9999, 8'd1, 1'b0, 2'd1};
    frame_table[10] = '{2'd1, 1'b0, 32'h33333333, 32'h44444444, 16'd5000, 16'd6000,
                        16'h7e7e, 8'd12, 1'b1, 2'd0};
    frame_table[11] = '{2'd3, 1'b0, 32'h55555555, 32'h66666666, 16'd7000, 16'd7001,
                        16'h0102, 8'd2, 1'b0, 2'd2};
endtask

`endif

/* verification/udp_demux_tb.sv */
/*
 * Testbench for the UDP demux top level. Sends the frames of the vector table,
 * scores every header and payload beat at the outputs and reports the error count.
 */
`timescale 1ns/1ps
`default_nettype none

module udp_demux_tb
    import udp_demux_pkg::*;
();

    `include "udp_demux_vectors.svh"

    typedef struct packed {
        logic [1:0] port;
        udp_hdr_t   hdr;
    } hdr_exp_t;

    typedef struct packed {
        logic [1:0]    port;
        payload_beat_t beat;
    } beat_exp_t;

    logic          clk;
    logic          rst;
    logic          s_hdr_valid;
    logic          s_hdr_ready;
    udp_hdr_t      s_hdr;
    logic          s_payload_valid;
    logic          s_payload_ready;
    payload_beat_t s_payload;
    logic [3:0]    m_hdr_valid;
    logic [3:0]    m_hdr_ready;
    udp_hdr_t      m_hdr;
    logic [3:0]    m_payload_valid;
    logic [3:0]    m_payload_ready;
    payload_beat_t m_payload;
    logic          enable;
    logic          drop;
    logic [1:0]    select;

    integer        seed = 26;
    int            error_count = 0;
    int            hdr_count = 0;
    int            beat_count = 0;
    int            cycle_count = 0;
    int            cycle_limit = 100000;
    logic          bp_active;
    logic          rst_d = 1'b0;
    logic          past_first_edge = 1'b0;

    hdr_exp_t      hdr_q[$];
    beat_exp_t     beat_q[$];
    payload_data_t data_pool[$];

    udp_demux_top #(
        .M_COUNT(4)
    ) dut0 (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_hdr           (s_hdr),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .s_payload       (s_payload),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr           (m_hdr),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .m_payload       (m_payload),
        .enable          (enable),
        .drop            (drop),
        .select          (select)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    // queue the expected outputs, then drive header and beats with handshakes
    task automatic send_frame(input frame_vec_t fv);
        udp_hdr_t      hdr;
        payload_beat_t beat;
        payload_beat_t frame_beats[$];
        hdr_exp_t      he;
        beat_exp_t     be;
        int            n;
        int            k;

        n = int'(fv.beats);
        hdr = '{fv.src_ip, fv.dst_ip, fv.src_port, fv.dst_port,
                udp_len_t'(8 + 4 * n), fv.csum};
        for (k = 0; k < n; k++) begin
            beat.data = data_pool.pop_front();
            beat.last = (k == n - 1);
            // partial keep only on the final beat
            beat.keep = beat.last ? (4'b1111 >> beat.data[1:0]) : 4'b1111;
            frame_beats.push_back(beat);
            be.port = fv.sel;
            be.beat = beat;
            if (!fv.drop) begin
                beat_q.push_back(be);
            end
        end
        he.port = fv.sel;
        he.hdr = hdr;
        if (!fv.drop) begin
            hdr_q.push_back(he);
        end

        bp_active = fv.bp;
        s_hdr = hdr;
        select = fv.sel;
        drop = fv.drop;
        s_hdr_valid = 1'b1;
        if (fv.en_mode == 2'd1) begin
            enable = 1'b0;
            repeat (8) @(negedge clk);
            enable = 1'b1;
        end
        @(posedge clk);
        while (!s_hdr_ready) @(posedge clk);
        @(negedge clk);
        s_hdr_valid = 1'b0;
        // the DUT holds its own copies of header and routing from here on
        s_hdr = udp_hdr_t'(~hdr);
        select = ~fv.sel;
        drop = ~fv.drop;

        for (k = 0; k < n; k++) begin
            s_payload = frame_beats[k];
            s_payload_valid = 1'b1;
            // beat held pending while the input side is paused
            if (fv.en_mode == 2'd2 && k == n / 2) begin
                enable = 1'b0;
                repeat (8) @(negedge clk);
                enable = 1'b1;
            end
            @(posedge clk);
            while (!s_payload_ready) @(posedge clk);
            @(negedge clk);
        end
        s_payload_valid = 1'b0;
    endtask

    // random ready patterns while the current frame asks for back-pressure
    initial begin
        logic bp_now;
        m_hdr_ready = '1;
        m_payload_ready = '1;
        bp_now = 1'b0;
        forever begin
            @(posedge clk);
            bp_now = bp_active;
            @(negedge clk);
            if (bp_now) begin
                m_payload_ready = 4'($random(seed));
                m_hdr_ready = 4'($random(seed));
            end else begin
                m_payload_ready = '1;
                m_hdr_ready = '1;
            end
        end
    end

    // scoreboard samples at the rising edge where transfers happen
    always @(posedge clk) begin
        hdr_exp_t  he;
        beat_exp_t be;
        if (past_first_edge && (rst || rst_d)) begin
            check_value("reset quiet", 128'd0,
                        128'({m_hdr_valid, m_payload_valid, s_hdr_ready, s_payload_ready}));
        end
        if (!rst && !enable) begin
            check_value("disabled readies", 128'd0, 128'({s_hdr_ready, s_payload_ready}));
        end
        check_value("header valid one-hot", 128'd1, 128'($countones(m_hdr_valid) <= 1));
        check_value("payload valid one-hot", 128'd1, 128'($countones(m_payload_valid) <= 1));
        if (!rst && |(m_hdr_valid & m_hdr_ready)) begin
            if (hdr_q.size() == 0) begin
                $display("error: header sent on ports %b while none was expected", m_hdr_valid);
                error_count++;
            end else begin
                he = hdr_q.pop_front();
                check_value("header port", 128'(4'(1) << he.port), 128'(m_hdr_valid));
                check_value("header fields", 128'(he.hdr), 128'(m_hdr));
                hdr_count++;
            end
        end
        if (!rst && |(m_payload_valid & m_payload_ready)) begin
            if (beat_q.size() == 0) begin
                $display("error: payload beat on ports %b while none was expected",
                         m_payload_valid);
                error_count++;
            end else begin
                be = beat_q.pop_front();
                check_value("payload port", 128'(4'(1) << be.port), 128'(m_payload_valid));
                check_value("payload beat", 128'(be.beat), 128'(m_payload));
                beat_count++;
            end
        end
        rst_d = rst;
        past_first_edge = 1'b1;
    end

    // cycle limit against a stalled DUT
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("error: run did not finish within %0d cycles, DUT stalled", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        int total;
        int i;
        int j;

        rst = 1'b1;
        enable = 1'b1;
        drop = 1'b0;
        select = '0;
        s_hdr_valid = 1'b0;
        s_hdr = '0;
        s_payload_valid = 1'b0;
        s_payload = '0;
        bp_active = 1'b0;

        load_frame_table();
        total = 0;
        for (i = 0; i < NUM_FRAMES; i++) begin
            total += int'(frame_table[i].beats) + 1;
            for (j = 0; j < int'(frame_table[i].beats); j++) begin
                data_pool.push_back(payload_data_t'($random(seed)));
            end
        end
        cycle_limit = 4 * total + 200;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < NUM_FRAMES; i++) begin
            send_frame(frame_table[i]);
        end
        bp_active = 1'b0;

        // drain, then watch for stray outputs
        while (hdr_q.size() != 0 || beat_q.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk);
        @(negedge clk);

        $display("%0d errors, %0d headers and %0d payload beats checked",
                 error_count, hdr_count, beat_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+verification
hw/udp_demux_pkg.sv
hw/udp_frame_ctrl.sv
hw/udp_payload_skid.sv
hw/udp_demux_top.sv
verification/udp_demux_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the UDP demux testbench with Verilator and run it.
# Exit status is nonzero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module udp_demux_tb -Mdir obj_dir \
    && ./obj_dir/Vudp_demux_tb | tee /dev/stderr | grep -q "Test passed" \
    && echo "simulation run: pass" \
    || { echo "simulation run: fail"; exit 1; }
